// ==== common/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // Instruction address width
    localparam int xlen = 32;

    // Line number within the 64 KiB program space from address bits 15:3
    localparam int line_num_bits = 13;

    // Byte address; bits 2:0 pick a byte inside a line
    typedef logic [xlen-1:0] addr_t;

    typedef logic [line_num_bits-1:0] line_num_t;

    // One cache line, which is also one fetch word
    typedef logic [63:0] line_t;

    // Bus transaction tag where zero means no transaction
    typedef logic [3:0] mem_tag_t;

    typedef enum logic [1:0] {
        bus_none = 2'b00,
        bus_load = 2'b01
    } bus_command_t;

endpackage

`default_nettype wire

// ==== icache/icache.sv ====
`default_nettype none

module icache
    import icache_pkg::*;
#(
    parameter int cache_lines = 32
) (
    input  logic         clock,
    input  logic         reset,
    input  addr_t        fetch_addr,
    input  mem_tag_t     mem_response,
    input  line_t        mem_data,
    input  mem_tag_t     mem_tag,
    output bus_command_t mem_command,
    output addr_t        mem_addr,
    output line_t        icache_data,
    output logic         icache_valid
);

    localparam int index_bits = $clog2(cache_lines);
    localparam int tag_bits   = line_num_bits - index_bits;

    typedef logic [index_bits-1:0] index_t;
    typedef logic [tag_bits-1:0]   line_tag_t;

    line_num_t line_num;
    line_num_t last_line_num;
    index_t    index;
    line_tag_t tag;

    mem_tag_t  pending_tag;        // Tag of the accepted load we wait for
    logic      miss_outstanding;   // Load not yet accepted by memory
    logic      changed_addr;
    logic      write_enable;
    logic      next_miss;

    line_t     data [cache_lines];
    line_tag_t tags [cache_lines];
    logic [cache_lines-1:0] valids;

    assign line_num     = fetch_addr[3 +: line_num_bits];
    assign {tag, index} = line_num;

    assign changed_addr = line_num != last_line_num;

    // Returning data only counts for the address that asked for it
    assign write_enable = (mem_tag == pending_tag) && (pending_tag != '0) && !changed_addr;

    // A new address starts a miss if it does not hit; a refused load keeps it open
    assign next_miss = changed_addr ? !icache_valid
                                    : (miss_outstanding && (mem_response == '0));

    assign mem_command = (miss_outstanding && !changed_addr) ? bus_load : bus_none;
    assign mem_addr    = {fetch_addr[xlen-1:3], 3'b000};

    assign icache_data  = valids[index] ? data[index] : '0;
    assign icache_valid = valids[index] && (tags[index] == tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            last_line_num    <= '1;   // All ones so the first fetch looks like a change
            pending_tag      <= '0;
            miss_outstanding <= 1'b0;
            valids           <= '0;
        end else begin
            last_line_num    <= line_num;
            miss_outstanding <= next_miss;

            // While a load is offered, capture whatever tag the memory answers with
            if (miss_outstanding) begin
                pending_tag <= mem_response;
            end else if (changed_addr || write_enable) begin
                pending_tag <= '0;   // Drops a load that is still in flight
            end

            if (write_enable) begin
                valids[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_enable) begin
            data[index] <= mem_data;
            tags[index] <= tag;
        end
    end

    // A load is only offered while the miss has not been accepted yet
    assert property (@(posedge clock) disable iff (reset)
        (mem_command == bus_load) |-> miss_outstanding);

    // Fills come only from a real returning transaction
    assert property (@(posedge clock) disable iff (reset)
        write_enable |-> (mem_tag != '0));

endmodule

`default_nettype wire

// ==== source/imem.sv ====
`default_nettype none

module imem
    import icache_pkg::*;
#(
    parameter int mem_words   = 1024,
    parameter int mem_latency = 4
) (
    input  logic         clock,
    input  logic         reset,
    input  bus_command_t mem_command,
    input  addr_t        mem_addr,
    input  logic         load_enable,
    input  addr_t        load_addr,
    input  line_t        load_data,
    output mem_tag_t     mem_response,
    output line_t        mem_data,
    output mem_tag_t     mem_tag
);

    localparam int word_bits = $clog2(mem_words);

    typedef logic [word_bits-1:0] word_index_t;

    line_t       lines [mem_words];
    mem_tag_t    next_tag;
    logic        accept;

    // Response pipeline with one stage per cycle of latency
    mem_tag_t    pipe_tag  [mem_latency];
    word_index_t pipe_addr [mem_latency];

    // The load port owns the memory while it is active
    assign accept       = (mem_command == bus_load) && !load_enable;
    assign mem_response = accept ? next_tag : '0;

    always_ff @(posedge clock) begin
        if (load_enable) begin
            lines[load_addr[3 +: word_bits]] <= load_data;
        end
    end

    // Tags rotate through 1 to 15 and never hand out 0
    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= mem_tag_t'(1);
        end else if (accept) begin
            if (next_tag == '1) begin
                next_tag <= mem_tag_t'(1);
            end else begin
                next_tag <= next_tag + mem_tag_t'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < mem_latency; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            pipe_tag[0] <= mem_response;   // Zero when nothing was accepted
            for (int i = 1; i < mem_latency; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        pipe_addr[0] <= mem_addr[3 +: word_bits];
        for (int i = 1; i < mem_latency; i++) begin
            pipe_addr[i] <= pipe_addr[i-1];
        end
    end

    // Last stage reads the array
    assign mem_tag  = pipe_tag[mem_latency-1];
    assign mem_data = lines[pipe_addr[mem_latency-1]];

    assert property (@(posedge clock)
        load_enable |-> (mem_response == '0));

    // An accepted load comes back with its own tag exactly mem_latency cycles later
    assert property (@(posedge clock) disable iff (reset)
        $past((mem_command == bus_load) && (mem_response != '0), mem_latency)
            |-> (mem_tag == $past(mem_response, mem_latency)));

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`default_nettype none

module fetch_unit
    import icache_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    input  logic  stall,
    input  line_t icache_data,
    input  logic  icache_valid,
    output addr_t fetch_addr,
    output logic  fetch_valid,
    output addr_t fetch_pc,
    output line_t fetch_bits
);

    addr_t pc;
    addr_t pc_next;

    // Redirect beats stall, stall beats advance
    always_comb begin
        pc_next = pc;
        if (redirect_valid) begin
            pc_next = {redirect_pc[xlen-1:3], 3'b000};   // Align to a line
        end else if (icache_valid && !stall) begin
            pc_next = pc + addr_t'(8);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign fetch_addr  = pc;
    assign fetch_pc    = pc;

    // A fetch is good as soon as the cache hits on the current pc
    assign fetch_valid = icache_valid;
    assign fetch_bits  = icache_data;

    assert property (@(posedge clock) disable iff (reset)
        fetch_pc[2:0] == 3'b000);

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
`default_nettype none

module fetch_top
    import icache_pkg::*;
#(
    parameter int cache_lines = 32,
    parameter int mem_latency = 4,
    parameter int mem_words   = 1024
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    input  logic  stall,
    input  logic  load_enable,
    input  addr_t load_addr,
    input  line_t load_data,
    output logic  fetch_valid,
    output addr_t fetch_pc,
    output line_t fetch_bits
);

    addr_t        fetch_addr;
    line_t        icache_data;
    logic         icache_valid;

    // Cache to memory bus
    bus_command_t mem_command;
    addr_t        mem_addr;
    mem_tag_t     mem_response;
    line_t        mem_data;
    mem_tag_t     mem_tag;

    fetch_unit u_fetch_unit (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .stall          (stall),
        .icache_data    (icache_data),
        .icache_valid   (icache_valid),
        .fetch_addr     (fetch_addr),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_bits     (fetch_bits)
    );

    icache #(
        .cache_lines (cache_lines)
    ) u_icache (
        .clock        (clock),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .mem_response (mem_response),
        .mem_data     (mem_data),
        .mem_tag      (mem_tag),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .icache_data  (icache_data),
        .icache_valid (icache_valid)
    );

    imem #(
        .mem_words   (mem_words),
        .mem_latency (mem_latency)
    ) u_imem (
        .clock        (clock),
        .reset        (reset),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .load_enable  (load_enable),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .mem_response (mem_response),
        .mem_data     (mem_data),
        .mem_tag      (mem_tag)
    );

endmodule

`default_nettype wire

// ==== verif/fetch_ref.svh ====
`ifndef fetch_ref_svh
`define fetch_ref_svh

// Copy of the program as written through the load port with one entry per line number
line_t shadow [2**line_num_bits];

function automatic addr_t line_pc(int line);
    return addr_t'(line) << 3;
endfunction

// The word that a correct fetch of pc returns
function automatic line_t expected_line(addr_t pc);
    return shadow[pc[15:3]];
endfunction

// Writes random lines through the load port while reset is high
task automatic load_program();
    line_t word;
    for (int i = 0; i < prog_lines; i++) begin
        word = {$urandom(), $urandom()};
        @(negedge clock);
        load_enable = 1'b1;
        load_addr   = line_pc(i);
        load_data   = word;
        shadow[line_num_t'(i)] = word;
    end
    @(negedge clock);
    load_enable = 1'b0;
endtask

// One cycle of redirect, returns in the cycle after the redirect edge
task automatic send_redirect(addr_t target);
    @(negedge clock);
    redirect_valid = 1'b1;
    redirect_pc    = target;
    @(negedge clock);
    redirect_valid = 1'b0;
endtask

task automatic wait_valid();
    int waited;
    waited = 0;
    while (!fetch_valid && waited < 2 * miss_cycles) begin
        @(negedge clock);
        waited++;
    end
    assert (fetch_valid) else begin
        error_count++;
        $display("%s: fetch_valid did not rise within %0d cycles", test_name, 2 * miss_cycles);
    end
endtask

// Stalls on a valid fetch, checks that it holds, then checks the next pc after release
task automatic hold_stall(int cycles);
    addr_t held_pc;
    line_t held_bits;
    stall = 1'b1;
    wait_valid();
    held_pc   = fetch_pc;
    held_bits = fetch_bits;
    repeat (cycles) begin
        @(negedge clock);
        assert (fetch_pc == held_pc) else begin
            error_count++;
            $display("[FAIL] %s: held fetch_pc expected %h, actual %h",
                     test_name, held_pc, fetch_pc);
        end
        assert (fetch_bits == held_bits) else begin
            error_count++;
            $display("[FAIL] %s: held fetch_bits expected %h, actual %h",
                     test_name, held_bits, fetch_bits);
        end
    end
    stall = 1'b0;
    @(negedge clock);
    assert (fetch_pc == held_pc + addr_t'(8)) else begin
        error_count++;
        $display("[FAIL] %s: pc after release expected %h, actual %h",
                 test_name, held_pc + addr_t'(8), fetch_pc);
    end
endtask

`endif

// ==== verif/tb_fetch_top.sv ====
`default_nettype none

module tb_fetch_top
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int reset_cycles    = 8;
    localparam int prog_lines      = 256;
    localparam int mem_latency     = 4;
    localparam int miss_cycles     = mem_latency + 4;
    localparam int conflict_rounds = 4;
    localparam int random_cycles   = 3000;

    // Load, reset, stream, hits, conflicts, stall, redirects during a miss, random run
    localparam int test_cycles = prog_lines + reset_cycles + 64 + 2 + 2 * conflict_rounds
                               + 17 + 4 + random_cycles + 2 * miss_cycles;
    localparam int watchdog_cycles = test_cycles * miss_cycles;

    logic  clock;
    logic  reset;
    logic  redirect_valid;
    addr_t redirect_pc;
    logic  stall;
    logic  load_enable;
    addr_t load_addr;
    line_t load_data;
    logic  fetch_valid;
    addr_t fetch_pc;
    line_t fetch_bits;

    int    error_count = 0;
    int    check_count = 0;
    int    fetch_count = 0;
    string test_name = "load";
    addr_t exp_pc;

    `include "fetch_ref.svh"

    fetch_top u_dut (
        .clock          (clock),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .stall          (stall),
        .load_enable    (load_enable),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_bits     (fetch_bits)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        if (reset) begin
            exp_pc = '0;
        end else begin
            if (fetch_valid) begin
                check_count++;
                assert (fetch_pc == exp_pc) else begin
                    error_count++;
                    $display("[FAIL] %s: fetch_pc expected %h, actual %h",
                             test_name, exp_pc, fetch_pc);
                end
                assert (fetch_bits == expected_line(fetch_pc)) else begin
                    error_count++;
                    $display("[FAIL] %s: fetch_bits at %h expected %h, actual %h",
                             test_name, fetch_pc, expected_line(fetch_pc), fetch_bits);
                end
            end
            if (redirect_valid) begin
                exp_pc = redirect_pc & ~addr_t'(7);   // Redirect wins over stall
            end else if (fetch_valid && !stall) begin
                exp_pc = exp_pc + addr_t'(8);
                fetch_count++;
            end
        end
    end

    task automatic wait_fetches(int count);
        int target;
        int waited;
        target = fetch_count + count;
        waited = 0;
        while (fetch_count < target && waited < count * miss_cycles) begin
            @(negedge clock);
            waited++;
        end
        assert (fetch_count >= target) else begin
            error_count++;
            $display("%s: %0d fetches did not complete in time", test_name, count);
        end
    endtask

    task automatic expect_hit(addr_t target);
        assert (fetch_valid) else begin
            error_count++;
            $display("%s: no hit in the cycle after the redirect to %h", test_name, target);
        end
    endtask

    // Second redirect lands after the first load was accepted but before it returns
    task automatic redirect_during_miss(int first, int second);
        send_redirect(line_pc(first));
        @(negedge clock);
        send_redirect(line_pc(second));
        wait_valid();
        repeat (2 * miss_cycles) begin
            @(negedge clock);
            assert (fetch_valid && fetch_bits == expected_line(line_pc(second))) else begin
                error_count++;
                $display("[FAIL] %s: fetch_bits expected %h, actual %h",
                         test_name, expected_line(line_pc(second)), fetch_bits);
            end
        end
    endtask

    task automatic run_random(int cycles);
        int start;
        start = fetch_count;
        repeat (cycles) begin
            @(negedge clock);
            // Forced redirect keeps the stream inside the loaded program
            if (int'(fetch_pc[15:3]) >= prog_lines - 8 || $urandom_range(15) == 0) begin
                redirect_valid = 1'b1;
                redirect_pc    = line_pc($urandom_range(prog_lines - 9))
                               | addr_t'($urandom_range(7));
            end else begin
                redirect_valid = 1'b0;
            end
            stall = ($urandom_range(3) == 0);
        end
        @(negedge clock);
        redirect_valid = 1'b0;
        stall          = 1'b0;
        assert (fetch_count - start > cycles / 30) else begin
            error_count++;
            $display("%s: only %0d lines fetched", test_name, fetch_count - start);
        end
    endtask

    initial begin
        void'($urandom(32'h95cf));
        clock          = 1'b0;
        reset          = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        stall          = 1'b0;
        load_enable    = 1'b0;
        load_addr      = '0;
        load_data      = '0;

        // Reset stays high through the program load and then for 8 more cycles
        load_program();
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;

        test_name = "reset_stream";
        assert (!fetch_valid) else begin
            error_count++;
            $display("%s: fetch_valid high in the first cycle after reset", test_name);
        end
        wait_fetches(64);
        stall = 1'b1;

        test_name = "redirect_hit";
        send_redirect(line_pc(40) | addr_t'(5));
        expect_hit(line_pc(40));
        send_redirect(line_pc(50));
        expect_hit(line_pc(50));

        test_name = "conflict";
        for (int round = 0; round < conflict_rounds; round++) begin
            send_redirect(line_pc(70));
            wait_valid();
            send_redirect(line_pc(102) | addr_t'(3));   // Same index as line 70 with another tag
            wait_valid();
        end

        test_name = "stall";
        send_redirect(line_pc(120));
        wait_valid();
        stall = 1'b0;
        wait_fetches(3);
        hold_stall(10);
        wait_fetches(4);
        stall = 1'b1;

        test_name = "redirect_miss";
        redirect_during_miss(140, 172);
        redirect_during_miss(145, 150);

        test_name = "random";
        run_random(random_cycles);
        repeat (2 * miss_cycles) @(negedge clock);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verif
common/icache_pkg.sv
icache/icache.sv
source/imem.sv
source/fetch_unit.sv
source/fetch_top.sv
verif/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the fetch subsystem testbench with Verilator and runs it.
# Exits nonzero unless the run prints the pass line.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
top=tb_fetch_top

verilator --binary --timing --assert -j 0 \
    --top-module "$top" \
    --Mdir "$build_dir" \
    -o "$top" \
    -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$build_dir/$top")
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1
